// File: Bender.yml
package:
  name: snb

sources:
  # Package first, then leaf modules, then the top level
  - design/snb_pkg.sv
  - design/snb_entry_array.sv
  - design/snb_age_matrix.sv
  - design/snb_oldest_sel.sv
  - design/snb_issue_arb.sv
  - design/snb_top.sv

  # Testbench, top module snb_tb
  - target: simulation
    files:
      - verification/snb_tb.sv

// File: design/snb_age_matrix.sv
// Snoop buffer age matrix
`timescale 1ns/1ps

module snb_age_matrix (
  input  logic                          clk,
  input  logic                          arst_n,
  input  logic                          alloc_vld,
  input  logic [snb_pkg::snb_idx_w-1:0] alloc_idx,
  input  logic                          free_vld,
  input  logic [snb_pkg::snb_idx_w-1:0] free_idx,
  input  logic [snb_pkg::snb_depth-1:0] entry_vld,
  output snb_pkg::snb_age_t             age_rows
);
  import snb_pkg::*;

  snb_age_t age_nxt;

  always_comb begin
    age_nxt = age_rows;

    if (alloc_vld) begin
      // Newcomer is younger than every entry present
      for (int i = 0; i < snb_depth; i++) begin
        age_nxt[i][alloc_idx] = 1'b0;
      end
      // Everything valid now is older than it
      // own valid bit not yet set, so diagonal stays clear
      age_nxt[alloc_idx] = entry_vld;
    end

    // Drop the freed entry from all rows
    // applied last, so a same-edge alloc row loses it too
    if (free_vld) begin
      for (int i = 0; i < snb_depth; i++) begin
        age_nxt[i][free_idx] = 1'b0;
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      age_rows <= '0;
    end else begin
      age_rows <= age_nxt;
    end
  end

endmodule

// File: design/snb_entry_array.sv
// Snoop buffer entry array
`timescale 1ns/1ps

module snb_entry_array (
  input  logic                                          clk,
  input  logic                                          arst_n,
  input  logic                                          wb_cyc,
  input  logic                                          wb_stb,
  input  logic                                          wb_we,
  input  logic                                          wb_adr,
  input  logic [31:0]                                   wb_dat_w,
  output logic [31:0]                                   wb_dat_r,
  output logic                                          wb_ack,
  output logic                                          wb_err,
  input  logic                                          grant_vld,
  input  logic [snb_pkg::snb_idx_w-1:0]                 grant_idx,
  input  logic                                          free_vld,
  input  logic [snb_pkg::snb_idx_w-1:0]                 free_idx,
  output snb_pkg::snb_entry_t [snb_pkg::snb_depth-1:0] entries,
  output logic [snb_pkg::snb_depth-1:0]                 entry_vld,
  output logic [snb_pkg::snb_depth-1:0]                 data_req,
  output logic [snb_pkg::snb_depth-1:0]                 resp_req,
  output logic                                          alloc_vld,
  output logic [snb_pkg::snb_idx_w-1:0]                 alloc_idx
);
  import snb_pkg::*;

  logic                 wb_hold;
  logic                 wb_req;
  logic                 push_req;
  logic                 cnt_rd;
  logic                 store;
  logic                 free_any;
  logic [snb_idx_w-1:0] free_sel;
  logic [snb_depth-1:0] free_mask;
  logic [snb_depth-1:0] entry_gnt;
  logic [snb_cnt_w-1:0] occ_cnt;

  // New request only once the previous answer has been seen off
  assign wb_req   = wb_cyc & wb_stb & ~wb_hold;
  assign push_req = wb_req & wb_we & (wb_adr == snb_adr_push);
  assign cnt_rd   = wb_req & ~wb_we & (wb_adr == snb_adr_count);
  // Push lands only when a slot is free
  assign store    = push_req & free_any;

  // Free slots, minus the one whose valid bit is still pending
  always_comb begin
    free_mask = ~entry_vld;
    if (alloc_vld) begin
      free_mask[alloc_idx] = 1'b0;
    end
  end

  // Lowest free index wins
  always_comb begin
    free_any = 1'b0;
    free_sel = '0;
    for (int i = snb_depth - 1; i >= 0; i--) begin
      if (free_mask[i]) begin
        free_any = 1'b1;
        free_sel = snb_idx_w'(i);
      end
    end
  end

  // One-cycle answer, then wait for stb to drop
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wb_ack   <= 1'b0;
      wb_err   <= 1'b0;
      wb_hold  <= 1'b0;
      wb_dat_r <= '0;
      alloc_vld <= 1'b0;
    end else begin
      // Full buffer push gets err, everything else ack
      wb_ack <= wb_req & ~(push_req & ~free_any);
      wb_err <= push_req & ~free_any;
      if (wb_req) begin
        wb_hold <= 1'b1;
      end else if (!(wb_cyc && wb_stb)) begin
        wb_hold <= 1'b0;
      end
      if (wb_req) begin
        wb_dat_r <= cnt_rd ? 32'(occ_cnt) : '0;
      end
      // Pulses alongside the ack
      alloc_vld <= store;
    end
  end

  // Snoop payload and the slot it went to
  always_ff @(posedge clk) begin
    if (store) begin
      entries[free_sel] <= snb_entry_t'(wb_dat_w[$bits(snb_entry_t)-1:0]);
      alloc_idx         <= free_sel;
    end
  end

  // Valid and granted bits, occupancy
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      entry_vld <= '0;
      entry_gnt <= '0;
      occ_cnt   <= '0;
    end else begin
      if (alloc_vld) begin
        entry_vld[alloc_idx] <= 1'b1;
      end
      if (grant_vld) begin
        entry_gnt[grant_idx] <= 1'b1;
      end
      // Free never hits the slot being allocated
      if (free_vld) begin
        entry_vld[free_idx] <= 1'b0;
        entry_gnt[free_idx] <= 1'b0;
      end
      occ_cnt <= occ_cnt + snb_cnt_w'(alloc_vld) - snb_cnt_w'(free_vld);
    end
  end

  // Ungranted valid entries, split by class
  always_comb begin
    for (int i = 0; i < snb_depth; i++) begin
      data_req[i] = entry_vld[i] & ~entry_gnt[i] &
                    (snb_op_class(entries[i].op) == class_data);
      resp_req[i] = entry_vld[i] & ~entry_gnt[i] &
                    (snb_op_class(entries[i].op) == class_resp);
    end
  end

endmodule

// File: design/snb_issue_arb.sv
// Snoop issue arbiter
`timescale 1ns/1ps

module snb_issue_arb (
  input  logic                                          clk,
  input  logic                                          arst_n,
  input  logic [snb_pkg::snb_depth-1:0]                 data_win,
  input  logic [snb_pkg::snb_depth-1:0]                 resp_win,
  input  snb_pkg::snb_entry_t [snb_pkg::snb_depth-1:0] entries,
  input  logic                                          issue_ready,
  output logic                                          issue_valid,
  output snb_pkg::snb_issue_t                           issue,
  output logic                                          grant_vld,
  output logic [snb_pkg::snb_idx_w-1:0]                 grant_idx,
  output logic                                          free_vld,
  output logic [snb_pkg::snb_idx_w-1:0]                 free_idx
);
  import snb_pkg::*;

  snb_class_e           last_cls;
  logic                 data_any;
  logic                 resp_any;
  logic                 pick_data;
  logic                 load;
  logic                 xfer;
  logic [snb_depth-1:0] win_vec;
  logic [snb_idx_w-1:0] win_idx;

  assign data_any = |data_win;
  assign resp_any = |resp_win;

  // Data if alone, or if response went last
  assign pick_data = data_any & (~resp_any | (last_cls == class_resp));
  assign win_vec   = pick_data ? data_win : resp_win;

  // One-hot to index
  always_comb begin
    win_idx = '0;
    for (int i = 0; i < snb_depth; i++) begin
      if (win_vec[i]) begin
        win_idx = win_idx | snb_idx_w'(i);
      end
    end
  end

  assign xfer = issue_valid & issue_ready;
  // Register empty or emptying this cycle
  assign load = (data_any | resp_any) & (~issue_valid | issue_ready);

  // Granted entry leaves the request vectors
  assign grant_vld = load;
  assign grant_idx = win_idx;
  // Slot released on the handshake
  assign free_vld  = xfer;
  assign free_idx  = issue.idx;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      issue_valid <= 1'b0;
      last_cls    <= class_resp;
    end else begin
      if (load) begin
        issue_valid <= 1'b1;
        last_cls    <= pick_data ? class_data : class_resp;
      end else if (xfer) begin
        issue_valid <= 1'b0;
      end
    end
  end

  // Held stable while stalled
  always_ff @(posedge clk) begin
    if (load) begin
      issue.idx   <= win_idx;
      issue.entry <= entries[win_idx];
    end
  end

endmodule

// File: design/snb_oldest_sel.sv
// Oldest requesting entry selector
`timescale 1ns/1ps

module snb_oldest_sel (
  input  logic [snb_pkg::snb_depth-1:0] req_vld,
  input  snb_pkg::snb_age_t             age_rows,
  output logic [snb_pkg::snb_depth-1:0] sel
);
  import snb_pkg::*;

  // Entry wins if nothing older is also requesting
  // total order among valid entries keeps sel one-hot
  always_comb begin
    for (int i = 0; i < snb_depth; i++) begin
      sel[i] = req_vld[i] & ~(|(req_vld & age_rows[i]));
    end
  end

endmodule

// File: design/snb_pkg.sv
// Snoop buffer shared definitions
package snb_pkg;

  // Buffer geometry
  localparam int snb_depth = 16;
  localparam int snb_idx_w = 4;
  // Field widths of a stored snoop
  localparam int snb_tag_w = 20;
  localparam int snb_src_w = 4;
  // Occupancy count, wide enough to hold a full buffer
  localparam int snb_cnt_w = 5;

  // Wishbone word addresses
  localparam logic snb_adr_push  = 1'b0;
  localparam logic snb_adr_count = 1'b1;

  // Snoop opcodes as carried in write data bits 25:24
  typedef enum logic [1:0] {
    snp_read_shared = 2'd0,
    snp_read_unique = 2'd1,
    snp_clean_inval = 2'd2,
    snp_make_inval  = 2'd3
  } snb_op_e;

  // Data path or response-only path
  typedef enum logic {
    class_data = 1'b0,
    class_resp = 1'b1
  } snb_class_e;

  // One stored snoop, op in the top bits, src in the bottom bits
  typedef struct packed {
    snb_op_e              op;
    logic [snb_tag_w-1:0] tag;
    logic [snb_src_w-1:0] src;
  } snb_entry_t;

  // What leaves on the issue port
  typedef struct packed {
    logic [snb_idx_w-1:0] idx;
    snb_entry_t           entry;
  } snb_issue_t;

  // Row i, bit j set: entry j arrived before entry i
  typedef logic [snb_depth-1:0][snb_depth-1:0] snb_age_t;

  // Reads return data, invalidates only a response
  function automatic snb_class_e snb_op_class(snb_op_e op);
    snb_op_class = (op == snp_read_shared || op == snp_read_unique) ? class_data : class_resp;
  endfunction

endpackage

// File: design/snb_top.sv
// Snoop buffer top level
`timescale 1ns/1ps

module snb_top (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                wb_cyc,
  input  logic                wb_stb,
  input  logic                wb_we,
  input  logic                wb_adr,
  input  logic [31:0]         wb_dat_w,
  output logic [31:0]         wb_dat_r,
  output logic                wb_ack,
  output logic                wb_err,
  output logic                issue_valid,
  output snb_pkg::snb_issue_t issue,
  input  logic                issue_ready
);
  import snb_pkg::*;

  // Entry contents and state
  snb_entry_t [snb_depth-1:0] entries;
  logic [snb_depth-1:0]       entry_vld;
  // Request vectors per class
  logic [snb_depth-1:0]       data_req;
  logic [snb_depth-1:0]       resp_req;
  // Oldest winners, one-hot
  logic [snb_depth-1:0]       data_win;
  logic [snb_depth-1:0]       resp_win;
  snb_age_t                   age_rows;
  logic                       alloc_vld;
  logic [snb_idx_w-1:0]       alloc_idx;
  logic                       grant_vld;
  logic [snb_idx_w-1:0]       grant_idx;
  logic                       free_vld;
  logic [snb_idx_w-1:0]       free_idx;

  snb_entry_array array0 (
    .clk       (clk),
    .arst_n    (arst_n),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_we     (wb_we),
    .wb_adr    (wb_adr),
    .wb_dat_w  (wb_dat_w),
    .wb_dat_r  (wb_dat_r),
    .wb_ack    (wb_ack),
    .wb_err    (wb_err),
    .grant_vld (grant_vld),
    .grant_idx (grant_idx),
    .free_vld  (free_vld),
    .free_idx  (free_idx),
    .entries   (entries),
    .entry_vld (entry_vld),
    .data_req  (data_req),
    .resp_req  (resp_req),
    .alloc_vld (alloc_vld),
    .alloc_idx (alloc_idx)
  );

  snb_age_matrix age0 (
    .clk       (clk),
    .arst_n    (arst_n),
    .alloc_vld (alloc_vld),
    .alloc_idx (alloc_idx),
    .free_vld  (free_vld),
    .free_idx  (free_idx),
    .entry_vld (entry_vld),
    .age_rows  (age_rows)
  );

  // Data path selector
  snb_oldest_sel data_sel0 (
    .req_vld  (data_req),
    .age_rows (age_rows),
    .sel      (data_win)
  );

  // Response path selector
  snb_oldest_sel resp_sel0 (
    .req_vld  (resp_req),
    .age_rows (age_rows),
    .sel      (resp_win)
  );

  snb_issue_arb arb0 (
    .clk         (clk),
    .arst_n      (arst_n),
    .data_win    (data_win),
    .resp_win    (resp_win),
    .entries     (entries),
    .issue_ready (issue_ready),
    .issue_valid (issue_valid),
    .issue       (issue),
    .grant_vld   (grant_vld),
    .grant_idx   (grant_idx),
    .free_vld    (free_vld),
    .free_idx    (free_idx)
  );

endmodule

// File: src.f
design/snb_pkg.sv
design/snb_entry_array.sv
design/snb_age_matrix.sv
design/snb_oldest_sel.sv
design/snb_issue_arb.sv
design/snb_top.sv
verification/snb_tb.sv

// File: verification/snb_tb.sv
// Snoop buffer testbench
`timescale 1ns/1ps

module snb_tb;
  import snb_pkg::*;

  logic        clk;
  logic        arst_n;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic        wb_adr;
  logic [31:0] wb_dat_w;
  logic [31:0] wb_dat_r;
  logic        wb_ack;
  logic        wb_err;
  logic        issue_valid;
  snb_issue_t  issue;
  logic        issue_ready;

  // 0 ready high, 1 held low, 2 random
  logic [1:0]  ready_mode;
  logic [31:0] lcg_state;
  // Monitor state
  snb_issue_t  got[$];
  logic        stall_seen;
  snb_issue_t  stall_issue;
  // Current record from the data file
  integer               fd;
  logic [8*16-1:0]      test_name;
  int                   hold;
  int                   stall;
  int                   n_push;
  int                   n_ord;
  int                   exp_errs;
  int                   exp_pcount;
  int                   exp_ecount;
  bit                   has_pcount;
  logic [1:0]           push_op [32];
  logic [snb_tag_w-1:0] push_tag [32];
  logic [snb_src_w-1:0] push_src [32];
  int                   ord [32];
  // Bookkeeping
  int test_errs;
  int total_errs;
  int pass_cnt;
  int fail_cnt;
  int wd_cycles;

  snb_top dut0 (
    .clk         (clk),
    .arst_n      (arst_n),
    .wb_cyc      (wb_cyc),
    .wb_stb      (wb_stb),
    .wb_we       (wb_we),
    .wb_adr      (wb_adr),
    .wb_dat_w    (wb_dat_w),
    .wb_dat_r    (wb_dat_r),
    .wb_ack      (wb_ack),
    .wb_err      (wb_err),
    .issue_valid (issue_valid),
    .issue       (issue),
    .issue_ready (issue_ready)
  );

  always #4 clk = ~clk;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("Error at %0t ns: %0s expected 0x%0h, got 0x%0h", $time, name, exp, act);
      test_errs++;
      total_errs++;
    end
  endtask

  // Sink side of the issue port
  always @(posedge clk) begin
    if (ready_mode == 2'd2) begin
      lcg_state = lcg_next(lcg_state);
      issue_ready <= lcg_state[16];
    end else begin
      issue_ready <= (ready_mode == 2'd0);
    end
  end

  // Records transfers and checks that a stalled snoop holds still
  always @(posedge clk) begin
    if (!arst_n) begin
      stall_seen = 1'b0;
    end else begin
      if (stall_seen) begin
        check_value("issue_valid", 1, issue_valid);
        check_value("issue", stall_issue, issue);
      end
      if (issue_valid && issue_ready) begin
        got.push_back(issue);
      end
      stall_seen  = issue_valid && !issue_ready;
      stall_issue = issue;
    end
  end

  // One classic cycle with the answer sampled at the edge
  task automatic wb_access(input logic we, input logic adr, input logic [31:0] wdat,
                           output logic [31:0] rdat, output logic got_err);
    int n;
    rdat    = '0;
    got_err = 1'b0;
    n       = 0;
    @(posedge clk);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= we;
    wb_adr   <= adr;
    wb_dat_w <= wdat;
    do begin
      @(posedge clk);
      n++;
    end while (!wb_ack && !wb_err && n < 16);
    if (wb_ack || wb_err) begin
      rdat    = wb_dat_r;
      got_err = wb_err;
    end else begin
      $display("Wishbone %0s at address %0d got no ack or err within 16 cycles",
               we ? "write" : "read", adr);
      test_errs++;
      total_errs++;
    end
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  // Reads tokens up to the end of the next record
  task automatic read_record(output bit found);
    logic [8*16-1:0]  kw;
    logic [8*128-1:0] line;
    bit               done;
    int               r;
    found = 1'b0;
    done  = 1'b0;
    while (!done) begin
      if ($fscanf(fd, "%s", kw) != 1) begin
        done = 1'b1;
      end else if (kw == "#") begin
        r = $fgets(line, fd);
      end else if (kw == "test") begin
        found      = 1'b1;
        r          = $fscanf(fd, "%s %d %d", test_name, hold, stall);
        n_push     = 0;
        n_ord      = 0;
        exp_errs   = 0;
        exp_ecount = 0;
        has_pcount = 1'b0;
      end else if (kw == "push") begin
        r = $fscanf(fd, "%d", n_push);
        for (int i = 0; i < n_push; i++) begin
          r = $fscanf(fd, "%h %h %h", push_op[i], push_tag[i], push_src[i]);
        end
      end else if (kw == "order") begin
        r = $fscanf(fd, "%d", n_ord);
        for (int i = 0; i < n_ord; i++) begin
          r = $fscanf(fd, "%d", ord[i]);
        end
      end else if (kw == "errs") begin
        r = $fscanf(fd, "%d", exp_errs);
      end else if (kw == "pcount") begin
        has_pcount = 1'b1;
        r = $fscanf(fd, "%d", exp_pcount);
      end else if (kw == "ecount") begin
        r = $fscanf(fd, "%d", exp_ecount);
      end else if (kw == "end") begin
        done = 1'b1;
      end
    end
  endtask

  task automatic run_test();
    logic [31:0] rdat;
    logic        err;
    int          n_err;
    int          wait_cyc;
    snb_issue_t  g;
    test_errs = 0;
    n_err     = 0;
    got.delete();
    check_value("issue_valid", 0, issue_valid);
    ready_mode <= hold ? 2'd1 : (stall ? 2'd2 : 2'd0);
    for (int i = 0; i < n_push; i++) begin
      wb_access(1'b1, snb_adr_push, {6'b0, push_op[i], push_tag[i], push_src[i]}, rdat, err);
      if (err) begin
        n_err++;
      end
    end
    check_value("wb_err count", exp_errs, n_err);
    if (has_pcount) begin
      wb_access(1'b0, snb_adr_count, '0, rdat, err);
      check_value("occupancy", exp_pcount, rdat);
    end
    // Release the sink and drain
    ready_mode <= stall ? 2'd2 : 2'd0;
    wait_cyc = 0;
    while (got.size() < n_ord && wait_cyc < 40 * (n_ord + 1)) begin
      @(posedge clk);
      wait_cyc++;
    end
    if (got.size() < n_ord) begin
      $display("Only %0d of %0d expected snoops were issued", got.size(), n_ord);
      test_errs++;
      total_errs++;
    end
    // Nothing extra may follow
    repeat (8) @(posedge clk);
    check_value("issue count", n_ord, got.size());
    for (int i = 0; i < n_ord && i < got.size(); i++) begin
      g = got[i];
      check_value("issue.idx", ord[i], g.idx);
      check_value("issue.op", push_op[ord[i]], g.entry.op);
      check_value("issue.tag", push_tag[ord[i]], g.entry.tag);
      check_value("issue.src", push_src[ord[i]], g.entry.src);
    end
    wb_access(1'b0, snb_adr_count, '0, rdat, err);
    check_value("occupancy", exp_ecount, rdat);
  endtask

  initial begin
    bit found;
    int budget;
    clk         = 1'b0;
    arst_n      = 1'b0;
    wb_cyc      = 1'b0;
    wb_stb      = 1'b0;
    wb_we       = 1'b0;
    wb_adr      = 1'b0;
    wb_dat_w    = '0;
    issue_ready = 1'b0;
    ready_mode  = 2'd1;
    lcg_state   = 32'd93;
    total_errs  = 0;
    pass_cnt    = 0;
    fail_cnt    = 0;
    wd_cycles   = 0;
    fd = $fopen("verification/snb_testdata.txt", "r");
    if (fd == 0) begin
      $display("Cannot open verification/snb_testdata.txt");
      $display("Testbench failed");
      $finish;
    end else begin
      // First pass sizes the watchdog
      budget = 10;
      do begin
        read_record(found);
        if (found) begin
          budget += 40 * (n_push + n_ord) + 40;
        end
      end while (found);
      wd_cycles = budget;
      $fclose(fd);
      fd = $fopen("verification/snb_testdata.txt", "r");
      repeat (10) @(posedge clk);
      arst_n <= 1'b1;
      @(posedge clk);
      read_record(found);
      while (found) begin
        run_test();
        if (test_errs == 0) begin
          pass_cnt++;
          $display("Test %0s: ok", test_name);
        end else begin
          fail_cnt++;
          $display("Test %0s: FAIL with %0d errors", test_name, test_errs);
        end
        read_record(found);
      end
      $fclose(fd);
      $display("Tests run: %0d, passed: %0d, failed: %0d", pass_cnt + fail_cnt, pass_cnt,
               fail_cnt);
      if (fail_cnt == 0 && total_errs == 0) begin
        $display("Testbench passed");
      end else begin
        $display("Testbench failed");
      end
      $finish;
    end
  end

  // Hard limit on the whole run
  initial begin
    wait (wd_cycles > 0);
    repeat (wd_cycles) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the run did not finish", wd_cycles);
    $display("Testbench failed");
    $finish;
  end

endmodule

// File: verification/snb_testdata.txt
# Record: test <name> <hold> <stall>, fields, end. hold keeps issue_ready low during pushes
# push <n> then n times <op tag src> in hex; order <n> then issued slots; errs/pcount/ecount
test reset 0 0
pcount 0
end
test single 0 0
push 1
  2 abcde 7
order 1 0
end
test same_class 1 0
push 5
  0 10000 1
  1 10001 2
  0 10002 3
  1 10003 4
  0 10004 5
pcount 5
order 5 0 1 2 3 4
end
test mixed 1 0
push 7
  1 20000 1  2 20001 2  3 20002 3
  0 20003 4  2 20004 5  3 20005 6
  1 20006 7
order 7 0 1 3 2 6 4 5
end
test overflow 1 0
push 17
  0 30000 0  1 30001 1  2 30002 2  0 30003 3
  3 30004 4  2 30005 5  1 30006 6  3 30007 7
  0 30008 8  1 30009 9  2 3000a a  3 3000b b
  2 3000c c  0 3000d d  3 3000e e  1 3000f f
  2 30010 0
errs 1
pcount 16
order 16 0 2 1 4 3 5 6 7 8 10 9 11 13 12 15 14
end
test random 1 1
push 8
  0 40000 1  1 40001 2  2 40002 3  1 40003 4
  3 40004 5  2 40005 6  0 40006 7  3 40007 8
order 8 0 2 1 4 3 5 6 7
end
